/* Makefile */
# Verilator build and run for the ORAM DRAM initializer testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= oramDramInitTb
FILELIST  ?= oramDramInit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/bucketAddrGen.sv */
/*
 * Bucket address generator
 * Issues one DRAM write command per bucket at its first word
 */
module bucketAddrGen (
	input  logic           Clock,
	input  logic           rst,
	input  logic           run,
	output ddrPkg::dramCmdT cmd,
	output logic           cmdValid,
	input  logic           cmdReady,
	output logic           finished
);

	import ddrPkg::*;
	import oramPkg::*;

	//----------------------------------------------------------------------
	// Address counter
	//----------------------------------------------------------------------

	// Word address of the bucket being offered
	logic [DdrAWidth-1:0] bucketAddr;

	// Last bucket already handed off
	logic atEnd;

	assign atEnd = bucketAddr >= DdrAWidth'(EndOfTreeAddr);

	// Step one bucket per accepted command
	always_ff @(posedge Clock) begin
		if (rst) begin
			bucketAddr <= '0;
		end else if (cmdValid && cmdReady) begin
			bucketAddr <= bucketAddr + DdrAWidth'(BktSizeDrWords);
		end
	end

	//----------------------------------------------------------------------
	// Command stream
	//----------------------------------------------------------------------

	// Offer while enabled and inside the tree
	assign cmdValid = run && !atEnd;

	// Every command is a write
	assign cmd.addr = bucketAddr;
	assign cmd.cmd = DdrCmdWrite;

	// All OramN commands accepted
	assign finished = atEnd;

endmodule

/* hw/bucketHeaderGen.sv */
/*
 * Bucket header generator
 * Emits one cleared header word per bucket with IVs seeded from its index
 */
module bucketHeaderGen (
	input  logic             Clock,
	input  logic             rst,
	input  logic             run,
	output ddrPkg::dramWriteT write,
	output logic             writeValid,
	input  logic             writeReady,
	output logic             finished
);

	import ddrPkg::*;
	import oramPkg::*;

	//----------------------------------------------------------------------
	// Bucket index
	//----------------------------------------------------------------------

	// Bucket whose header is on offer
	logic [BucketAWidth-1:0] bucketIdx;

	// Header being built for that bucket
	bucketHeaderT header;

	// Every bucket header handed off
	logic atEnd;

	assign atEnd = bucketIdx >= BucketAWidth'(OramN);

	// Advance on each accepted data beat
	always_ff @(posedge Clock) begin
		if (rst) begin
			bucketIdx <= '0;
		end else if (writeValid && writeReady) begin
			bucketIdx <= bucketIdx + 1'b1;
		end
	end

	//----------------------------------------------------------------------
	// Header word
	//----------------------------------------------------------------------

	always_comb begin
		// No block in the bucket holds real data yet
		header.valid = '0;
		// Index seeds the low IV
		header.ivLow = IvEntropyWidth'(bucketIdx);
		// And its complement the high IV
		header.ivHigh = ~IvEntropyWidth'(bucketIdx);
		header.spare = '0;
	end

	//----------------------------------------------------------------------
	// Write data stream
	//----------------------------------------------------------------------

	// Runs on its own
	// The controller matches data to commands in issue order
	assign writeValid = run && !atEnd;

	assign write.data = header;

	// Zero mask lets every byte through
	assign write.mask = {DdrMWidth{1'b0}};

	assign finished = atEnd;

endmodule

/* hw/ddrPkg.sv */
/*
 * DDR3 controller interface definitions
 * Port widths, command codes and the command and write beat layouts
 */
package ddrPkg;

	//----------------------------------------------------------------------
	// Interface widths
	//----------------------------------------------------------------------

	// Word address into DRAM
	localparam int DdrAWidth = 27;

	// Command code as seen by the controller
	localparam int DdrCWidth = 3;

	// One data beat on the write channel
	localparam int DdrDWidth = 64;

	// One mask bit per data byte
	localparam int DdrMWidth = DdrDWidth / 8;

	//----------------------------------------------------------------------
	// Command codes
	//----------------------------------------------------------------------

	// Controller write encoding
	localparam logic [DdrCWidth-1:0] DdrCmdWrite = 3'b000;

	//----------------------------------------------------------------------
	// Beat layouts
	//----------------------------------------------------------------------

	// Command channel beat
	typedef struct packed {
		logic [DdrAWidth-1:0] addr;
		logic [DdrCWidth-1:0] cmd;
	} dramCmdT;

	// Write data channel beat
	// A set mask bit blocks its byte, so all zeros writes the whole word
	typedef struct packed {
		logic [DdrDWidth-1:0] data;
		logic [DdrMWidth-1:0] mask;
	} dramWriteT;

endpackage

/* hw/dramSkidBuffer.sv */
/*
 * Two-entry skid buffer with registered outputs
 * Full throughput valid/ready stage for any payload type
 */
module dramSkidBuffer #(
	parameter type Payload = logic
) (
	input  logic   Clock,
	input  logic   rst,
	input  Payload in,
	input  logic   inValid,
	output logic   inReady,
	output Payload out,
	output logic   outValid,
	input  logic   outReady,
	output logic   empty
);

	//----------------------------------------------------------------------
	// Storage
	//----------------------------------------------------------------------

	// Second entry catches a beat while the output stalls
	Payload skidData;
	logic   skidValid;

	// Output slot frees up this cycle
	logic   outFree;

	assign outFree = outReady || !outValid;

	// Full only when the skid entry is taken
	assign inReady = !skidValid;

	//----------------------------------------------------------------------
	// Control
	//----------------------------------------------------------------------

	always_ff @(posedge Clock) begin
		if (rst) begin
			outValid <= 1'b0;
			skidValid <= 1'b0;
		end else if (outFree) begin
			// Skid entry goes first to keep order
			outValid <= skidValid || inValid;
			skidValid <= 1'b0;
		end else if (inValid && inReady) begin
			// Output stalled so park the new beat
			skidValid <= 1'b1;
		end
	end

	//----------------------------------------------------------------------
	// Payload
	//----------------------------------------------------------------------

	always_ff @(posedge Clock) begin
		if (outFree) begin
			out <= skidValid ? skidData : in;
		end
		if (!outFree && inReady) begin
			skidData <= in;
		end
	end

	// Nothing held in either entry
	assign empty = !outValid && !skidValid;

endmodule

/* hw/initSequencer.sv */
/*
 * Initialization sequencer
 * Starts both generators after calibration and reports when all beats are out
 */
module initSequencer (
	input  logic Clock,
	input  logic rst,
	input  logic calibDone,
	input  logic cmdFinished,
	input  logic writeFinished,
	input  logic cmdEmpty,
	input  logic writeEmpty,
	output logic run,
	output logic done
);

	//----------------------------------------------------------------------
	// State machine
	//----------------------------------------------------------------------

	typedef enum logic [1:0] {
		Waiting,
		Running,
		Complete
	} seqStateT;

	seqStateT state;

	// Both streams counted out and nothing left in flight
	logic drained;

	assign drained = cmdFinished && writeFinished && cmdEmpty && writeEmpty;

	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= Waiting;
		end else begin
			case (state)
				// Hold off until DRAM is calibrated
				Waiting: begin
					if (calibDone) begin
						state <= Running;
					end
				end
				// Last beat must leave both buffers
				Running: begin
					if (drained) begin
						state <= Complete;
					end
				end
				// Sticky until reset
				Complete: state <= Complete;
				default: state <= Waiting;
			endcase
		end
	end

	//----------------------------------------------------------------------
	// Outputs
	//----------------------------------------------------------------------

	// Generators stop on their own at the tree end
	assign run = state != Waiting;

	assign done = state == Complete;

endmodule

/* hw/oramDramInit.sv */
/*
 * ORAM DRAM initializer
 * Writes a cleared header into every bucket of the tree after calibration
 */
module oramDramInit (
	input  logic              Clock,
	input  logic              rst,
	input  logic              calibDone,

	// DRAM command channel
	output ddrPkg::dramCmdT   cmd,
	output logic              cmdValid,
	input  logic              cmdReady,

	// DRAM write data channel
	output ddrPkg::dramWriteT write,
	output logic              writeValid,
	input  logic              writeReady,

	// Tree ready for ORAM traffic
	output logic              done
);

	import ddrPkg::*;

	//----------------------------------------------------------------------
	// Internal streams
	//----------------------------------------------------------------------

	// Generator side of the command buffer
	dramCmdT   genCmd;
	logic      genCmdValid;
	logic      genCmdReady;

	// Generator side of the write buffer
	dramWriteT genWrite;
	logic      genWriteValid;
	logic      genWriteReady;

	// Status into the sequencer
	logic      run;
	logic      cmdFinished;
	logic      writeFinished;
	logic      cmdEmpty;
	logic      writeEmpty;

	//----------------------------------------------------------------------
	// Sequencing
	//----------------------------------------------------------------------

	initSequencer seq (
		.Clock        (Clock),
		.rst          (rst),
		.calibDone    (calibDone),
		.cmdFinished  (cmdFinished),
		.writeFinished(writeFinished),
		.cmdEmpty     (cmdEmpty),
		.writeEmpty   (writeEmpty),
		.run          (run),
		.done         (done)
	);

	//----------------------------------------------------------------------
	// Command path
	//----------------------------------------------------------------------

	bucketAddrGen addrGen (
		.Clock   (Clock),
		.rst     (rst),
		.run     (run),
		.cmd     (genCmd),
		.cmdValid(genCmdValid),
		.cmdReady(genCmdReady),
		.finished(cmdFinished)
	);

	dramSkidBuffer #(
		.Payload(dramCmdT)
	) cmdBuf (
		.Clock   (Clock),
		.rst     (rst),
		.in      (genCmd),
		.inValid (genCmdValid),
		.inReady (genCmdReady),
		.out     (cmd),
		.outValid(cmdValid),
		.outReady(cmdReady),
		.empty   (cmdEmpty)
	);

	//----------------------------------------------------------------------
	// Write data path
	//----------------------------------------------------------------------

	bucketHeaderGen headerGen (
		.Clock     (Clock),
		.rst       (rst),
		.run       (run),
		.write     (genWrite),
		.writeValid(genWriteValid),
		.writeReady(genWriteReady),
		.finished  (writeFinished)
	);

	dramSkidBuffer #(
		.Payload(dramWriteT)
	) writeBuf (
		.Clock   (Clock),
		.rst     (rst),
		.in      (genWrite),
		.inValid (genWriteValid),
		.inReady (genWriteReady),
		.out     (write),
		.outValid(writeValid),
		.outReady(writeReady),
		.empty   (writeEmpty)
	);

endmodule

/* hw/oramPkg.sv */
/*
 * Path ORAM tree geometry and bucket header layout
 */
package oramPkg;

	//----------------------------------------------------------------------
	// Tree geometry
	//----------------------------------------------------------------------

	// Buckets in the whole tree
	localparam int OramN = 16;

	// DRAM words taken by one bucket
	localparam int BktSizeDrWords = 4;

	// Bucket index range covers 0 up to OramN inclusive
	localparam int BucketAWidth = $clog2(OramN + 1);

	// First word address past the last bucket
	localparam int EndOfTreeAddr = OramN * BktSizeDrWords;

	//----------------------------------------------------------------------
	// Bucket header
	//----------------------------------------------------------------------

	// One valid bit per block slot
	localparam int ValidBits = 4;

	// Each of the two IV seed fields
	localparam int IvEntropyWidth = 16;

	// Whatever is left of the first DRAM word
	localparam int HdrSpare = ddrPkg::DdrDWidth - 2 * IvEntropyWidth - ValidBits;

	// Header word, declared high field first
	// Low bits up: ivLow, valid, ivHigh, spare
	typedef struct packed {
		logic [HdrSpare-1:0]       spare;
		logic [IvEntropyWidth-1:0] ivHigh;
		logic [ValidBits-1:0]      valid;
		logic [IvEntropyWidth-1:0] ivLow;
	} bucketHeaderT;

endpackage

/* oramDramInit.f */
hw/ddrPkg.sv
hw/oramPkg.sv
hw/dramSkidBuffer.sv
hw/bucketAddrGen.sv
hw/bucketHeaderGen.sv
hw/initSequencer.sv
hw/oramDramInit.sv
tb/tbClock.sv
tb/oramDramInitTb.sv

/* tb/oramDramInitTb.sv */
/*
 * Testbench for the ORAM DRAM initializer
 * Table-driven runs under random back-pressure, checking both streams and done
 */
module oramDramInitTb;

	timeunit 1ns;
	timeprecision 100ps;

	import ddrPkg::*;
	import oramPkg::*;

	//----------------------------------------------------------------------
	// Scenario table
	//----------------------------------------------------------------------

	typedef struct packed {
		int calibDelay;
		int cmdDensity;
		int writeDensity;
		int expectBeats;
	} scenarioT;

	localparam int NumRows = 4;
	localparam int SettleCycles = 10;
	localparam int ResetOverhead = 12;
	localparam int MarginCycles = 40;

	// Calib delay in cycles, ready chance in percent, beats per stream
	localparam scenarioT Rows [NumRows] = '{
		// No back-pressure
		'{0, 100, 100, OramN},
		// Light
		'{3, 80, 70, OramN},
		// Heavy
		'{5, 25, 30, OramN},
		// Command side only, late calibration
		'{20, 30, 100, OramN}
	};

	//----------------------------------------------------------------------
	// DUT and clock
	//----------------------------------------------------------------------

	logic      Clock;
	logic      rst;
	logic      resetReq = 1'b0;
	logic      calibDone;
	dramCmdT   cmd;
	logic      cmdValid;
	logic      cmdReady;
	dramWriteT write;
	logic      writeValid;
	logic      writeReady;
	logic      done;

	tbClock clockGen (
		.Clock   (Clock),
		.rst     (rst),
		.resetReq(resetReq)
	);

	oramDramInit UUT (
		.Clock     (Clock),
		.rst       (rst),
		.calibDone (calibDone),
		.cmd       (cmd),
		.cmdValid  (cmdValid),
		.cmdReady  (cmdReady),
		.write     (write),
		.writeValid(writeValid),
		.writeReady(writeReady),
		.done      (done)
	);

	// Error tallies and run bookkeeping
	int valueErrors = 0;
	int protocolErrors = 0;
	int cmdCount;
	int writeCount;
	int cycleCount = 0;
	int cycleLimit;
	logic [31:0] randState = 32'd65;

	// Monitor state carried from edge to edge
	logic      rstPrev = 1'b0;
	logic      calibSeen;
	logic      doneSeen;
	logic      cmdHeld;
	logic      writeHeld;
	dramCmdT   heldCmd;
	dramWriteT heldWrite;

	//----------------------------------------------------------------------
	// Helpers
	//----------------------------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// High with the given percent chance
	function logic drawReady(input int density);
		randState = xorshift32(randState);
		return (randState % 32'd100) < 32'(density);
	endfunction

	// Slowest stream sets the budget of each row
	function automatic int limitFromRows();
		int total;
		int slow;
		total = 0;
		for (int i = 0; i < NumRows; i++) begin
			slow = Rows[i].cmdDensity < Rows[i].writeDensity ?
				Rows[i].cmdDensity : Rows[i].writeDensity;
			total += OramN * 2 * 100 / slow + Rows[i].calibDelay
				+ ResetOverhead + SettleCycles + MarginCycles;
		end
		return total;
	endfunction

	task automatic compareField(input string what, input logic [127:0] got,
			input logic [127:0] expected);
		assert (got == expected) else begin
			valueErrors++;
			$display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	task automatic checkRule(input logic ok, input string what);
		assert (ok) else begin
			protocolErrors++;
			$display("Protocol error at %0d ns: %s", $time, what);
		end
	endtask

	//----------------------------------------------------------------------
	// Stream monitor, sampled on the rising edge
	//----------------------------------------------------------------------

	always @(posedge Clock) begin : streamMonitor
		bucketHeaderT hdr;
		logic [IvEntropyWidth-1:0] expIv;
		logic [IvEntropyWidth-1:0] expIvHigh;
		hdr = write.data;
		expIv = IvEntropyWidth'(writeCount);
		expIvHigh = ~expIv;
		if (rst) begin
			// First reset edge still sees unset flops
			if (rstPrev) begin
				checkRule(!cmdValid && !writeValid && !done, "output active during reset");
			end
			cmdCount = 0;
			writeCount = 0;
			calibSeen = 1'b0;
			doneSeen = 1'b0;
			cmdHeld = 1'b0;
			writeHeld = 1'b0;
		end else begin
			if (!calibSeen && !calibDone) begin
				checkRule(!cmdValid && !writeValid && !done, "output active before calibration");
			end
			calibSeen = calibSeen || calibDone;
			// Done is sticky and comes only after both streams
			if (done) begin
				checkRule(cmdCount == OramN && writeCount == OramN,
					"done raised before all beats were accepted");
			end
			if (doneSeen) begin
				checkRule(done, "done dropped before reset");
			end
			doneSeen = doneSeen || done;
			// Stalled beats must not move
			if (cmdHeld) begin
				checkRule(cmdValid, "command withdrawn before it was accepted");
				compareField("stalled command", 128'(cmd), 128'(heldCmd));
			end
			if (writeHeld) begin
				checkRule(writeValid, "write beat withdrawn before it was accepted");
				compareField("stalled write beat", 128'(write), 128'(heldWrite));
			end
			cmdHeld = cmdValid && !cmdReady;
			heldCmd = cmd;
			writeHeld = writeValid && !writeReady;
			heldWrite = write;
			// Command k targets the first word of bucket k
			if (cmdValid && cmdReady) begin
				checkRule(cmdCount < OramN, "command accepted after the last bucket");
				compareField("command address", 128'(cmd.addr),
					128'(cmdCount * BktSizeDrWords));
				compareField("command code", 128'(cmd.cmd), 128'(DdrCmdWrite));
				cmdCount++;
			end
			// Header k is cleared and seeded from k
			if (writeValid && writeReady) begin
				checkRule(writeCount < OramN, "write beat accepted after the last bucket");
				compareField("header valid bits", 128'(hdr.valid), 128'(0));
				compareField("header ivLow", 128'(hdr.ivLow), 128'(expIv));
				compareField("header ivHigh", 128'(hdr.ivHigh), 128'(expIvHigh));
				compareField("header spare bits", 128'(hdr.spare), 128'(0));
				// Set mask bit blocks a byte, so zero writes them all
				compareField("write mask", 128'(write.mask), 128'(0));
				writeCount++;
			end
		end
		rstPrev = rst;
	end

	// Watchdog
	always @(posedge Clock) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: done did not rise within %0d cycles", cycleLimit);
			$display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
			$display("Finished with errors");
			$finish;
		end
	end

	//----------------------------------------------------------------------
	// Stimulus, driven on the falling edge
	//----------------------------------------------------------------------

	task automatic runRow(input scenarioT row, input int index);
		int waited;
		$display("Scenario %0d: calib delay %0d, ready %0d and %0d percent",
			index, row.calibDelay, row.cmdDensity, row.writeDensity);
		@(negedge Clock);
		calibDone <= 1'b0;
		cmdReady <= 1'b0;
		writeReady <= 1'b0;
		resetReq <= 1'b1;
		@(negedge Clock);
		resetReq <= 1'b0;
		@(negedge Clock);
		while (rst) begin
			@(negedge Clock);
		end
		// Run until done, then keep going to catch stray beats
		waited = 0;
		while (!done) begin
			calibDone <= waited >= row.calibDelay;
			cmdReady <= drawReady(row.cmdDensity);
			writeReady <= drawReady(row.writeDensity);
			waited++;
			@(negedge Clock);
		end
		repeat (SettleCycles) begin
			cmdReady <= drawReady(row.cmdDensity);
			writeReady <= drawReady(row.writeDensity);
			@(negedge Clock);
		end
		compareField("commands accepted", 128'(cmdCount), 128'(row.expectBeats));
		compareField("write beats accepted", 128'(writeCount), 128'(row.expectBeats));
		checkRule(done, "done low at the end of the scenario");
	endtask

	initial begin
		calibDone = 1'b0;
		cmdReady = 1'b0;
		writeReady = 1'b0;
		cycleLimit = limitFromRows();
		for (int i = 0; i < NumRows; i++) begin
			runRow(Rows[i], i);
		end
		$display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* tb/tbClock.sv */
/*
 * Testbench clock and reset source
 * 20 ns clock, reset held for 8 cycles at start and on each request
 */
module tbClock (
	output logic Clock,
	output logic rst,
	input  logic resetReq
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int HalfPeriod = 10;
	localparam int ResetCycles = 8;

	// Falling edges left before reset drops
	int resetLeft = ResetCycles;

	initial begin
		Clock = 1'b0;
		rst = 1'b1;
	end

	always #HalfPeriod Clock = ~Clock;

	// Reset changes on the falling edge, half a cycle away from the DUT
	always @(negedge Clock) begin
		if (resetReq) begin
			rst <= 1'b1;
			resetLeft <= ResetCycles;
		end else if (resetLeft != 0) begin
			rst <= resetLeft > 1;
			resetLeft <= resetLeft - 1;
		end
	end

endmodule
